// ==== build.f ====
hw/uart_pkg.sv
hw/cmd_pkg.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/cmd_engine.sv
hw/uart_cmd_top.sv
tests/tb_uart_cmd.sv

// ==== run.sh ====
#!/bin/sh
# Compile with Verilator, run, then scan the log for the failure line
verilator --binary --timing --top-module tb_uart_cmd -f build.f -o tb_uart_cmd \
  && ./obj_dir/tb_uart_cmd > sim.log 2>&1 \
  && cat sim.log \
  && ! grep -q "Errors found" sim.log \
  && grep -q "No errors" sim.log \
  && echo "PASS" \
  || { cat sim.log 2>/dev/null; echo "FAIL"; exit 1; }

// ==== tests/tb_uart_cmd.sv ====
`timescale 1ns/10ps

module tb_uart_cmd
  import uart_pkg::*;
  import cmd_pkg::*;
();

  localparam int BIT_CYCLES  = 16;
  localparam int GAP_BITS    = 4;
  localparam int TIMEOUT     = 2000 * BIT_CYCLES;
  localparam int MIN_SPACING = (FRAME_BITS + GAP_BITS) * BIT_CYCLES;  // Start to start

  typedef struct packed {
    logic [1:0] count;
    uart_byte_t first;
    uart_byte_t second;
  } frames_t;

  logic      clk;
  logic      rst_n;
  cmd_t      cmd;
  logic      cmd_vld;
  logic      cmd_rdy;
  logic      rx;
  logic      tx;
  logic      read_rdy;
  read_rsp_t rsp;

  int          errors = 0;
  int          checks = 0;
  string       test_name = "none";
  logic [31:0] lfsr = 32'h5a705032;

  uart_byte_t exp_bytes[$];
  logic       exp_second[$];  // Set for the data frame of a write
  read_rsp_t  exp_rsps[$];
  uart_byte_t seen_bytes[$];
  int         seen_starts[$];

  logic       mon_busy = 1'b0;
  int         mon_cnt = 0;
  int         mon_bit = 0;
  int         mon_start = 0;
  int         cycle_cnt = 0;
  uart_byte_t mon_byte = '0;
  logic       mon_par = 1'b0;
  uart_byte_t got_byte;
  int         got_start;
  int         last_start = 0;
  logic       is_second;

  uart_cmd_top #(
    .BIT_CYCLES (BIT_CYCLES),
    .GAP_BITS   (GAP_BITS)
  ) dut0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd      (cmd),
    .cmd_vld  (cmd_vld),
    .cmd_rdy  (cmd_rdy),
    .rx       (rx),
    .tx       (tx),
    .read_rdy (read_rdy),
    .rsp      (rsp)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic parity_of(input uart_byte_t b);
    return ^b;  // Even parity bit
  endfunction

  // Expected tx frames with the command byte first and the data byte on a write
  function automatic frames_t frames_ref(input cmd_t c);
    frames_t f;
    f.first  = {c.rw, c.addr};
    f.second = c.data;
    f.count  = c.rw ? 2'd2 : 2'd1;
    return f;
  endfunction

  function automatic read_rsp_t rsp_ref(input uart_byte_t b, input logic bad_par,
                                        input logic bad_stop);
    read_rsp_t r;
    r.data = b;
    r.err  = bad_par | bad_stop;
    return r;
  endfunction

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
    end
    return v;
  endfunction

  task automatic compare_byte(input string name, input uart_byte_t exp, input uart_byte_t act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("** Error %s: expected %02h actual %02h", name, exp, act);
    end
  endtask

  task automatic compare_rsp(input string name, input read_rsp_t exp, input read_rsp_t act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("** Error %s: expected data %02h err %b actual data %02h err %b",
               name, exp.data, exp.err, act.data, act.err);
    end
  endtask

  task automatic compare_level(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("** Error %s: expected %b actual %b", name, exp, act);
    end
  endtask

  task automatic finish_run();
    $display("Checks: %0d  Failed: %0d", checks, errors);
    if (errors == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  endtask

  task automatic abort_on_timeout(input string what);
    errors++;
    $display("Timed out waiting for %s in test %s", what, test_name);
    finish_run();
  endtask

  // Takes a command on the next edge where cmd_rdy is high
  task automatic issue_cmd(input cmd_t c);
    frames_t f;
    int      n;
    f = frames_ref(c);
    n = 0;
    while (!cmd_rdy)
    begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT)
        abort_on_timeout("cmd_rdy");
    end
    cmd     = c;
    cmd_vld = 1'b1;
    exp_bytes.push_back(f.first);
    exp_second.push_back(1'b0);
    if (f.count == 2'd2)
    begin
      exp_bytes.push_back(f.second);
      exp_second.push_back(1'b1);
    end
    @(negedge clk);
    cmd_vld = 1'b0;
  endtask

  task automatic wait_frames_out();
    int n;
    n = 0;
    while (exp_bytes.size() != 0)
    begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT)
        abort_on_timeout("tx frames");
    end
  endtask

  task automatic wait_done();
    int n;
    n = 0;
    while (!(cmd_rdy && exp_bytes.size() == 0 && exp_rsps.size() == 0))
    begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT)
        abort_on_timeout("command to complete");
    end
  endtask

  // Line model that puts one frame LSB first on rx
  task automatic send_frame(input uart_byte_t b, input logic bad_par, input logic bad_stop);
    logic [10:0] bits;
    bits = {~bad_stop, parity_of(b) ^ bad_par, b, 1'b0};
    repeat (FRAME_BITS)
    begin
      rx   = bits[0];
      bits = bits >> 1;
      repeat (BIT_CYCLES) @(negedge clk);
    end
    rx = 1'b1;
  endtask

  task automatic run_write(input cmd_t c);
    issue_cmd(c);
    wait_done();
  endtask

  task automatic run_read(input cmd_t c, input uart_byte_t reply, input logic bad_par,
                          input logic bad_stop);
    exp_rsps.push_back(rsp_ref(reply, bad_par, bad_stop));
    issue_cmd(c);
    wait_frames_out();
    repeat (BIT_CYCLES) @(negedge clk);
    send_frame(reply, bad_par, bad_stop);
    wait_done();
  endtask

  // New values on cmd while the engine is busy and cmd_vld dropped before cmd_rdy returns
  task automatic hold_vld_while_busy(input int cycles);
    logic [31:0] r;
    for (int i = 0; i < cycles; i++)
    begin
      if (cmd_rdy)
        break;
      r       = rand_bits(16);
      cmd     = cmd_t'(r[15:0]);
      cmd_vld = 1'b1;
      @(negedge clk);
    end
    cmd_vld = 1'b0;
  endtask

  // tx monitor sampling each bit at its middle
  always @(negedge clk)
  begin
    cycle_cnt++;
    if (!rst_n)
      mon_busy = 1'b0;
    else if (!mon_busy)
    begin
      if (tx == 1'b0)
      begin
        mon_busy  = 1'b1;
        mon_cnt   = 0;
        mon_bit   = 0;
        mon_start = cycle_cnt;
      end
    end
    else
    begin
      mon_cnt++;
      if (mon_cnt == BIT_CYCLES / 2 + mon_bit * BIT_CYCLES)
      begin
        if (mon_bit == 0)
        begin
          if (tx != 1'b0)
          begin
            errors++;
            $display("Start bit on tx did not last to its middle in %s", test_name);
            mon_busy = 1'b0;
          end
        end
        else if (mon_bit <= 8)
          mon_byte = {tx, mon_byte[7:1]};
        else if (mon_bit == 9)
          mon_par = tx;
        else
        begin
          compare_level({test_name, " parity"}, parity_of(mon_byte), mon_par);
          compare_level({test_name, " stop bit"}, 1'b1, tx);
          seen_bytes.push_back(mon_byte);
          seen_starts.push_back(mon_start);
          mon_busy = 1'b0;
        end
        mon_bit++;
      end
    end
  end

  always @(negedge clk)
  begin
    if (seen_bytes.size() != 0)
    begin
      got_byte  = seen_bytes.pop_front();
      got_start = seen_starts.pop_front();
      if (exp_bytes.size() == 0)
      begin
        errors++;
        $display("Frame %02h showed up on tx with no command behind it in %s",
                 got_byte, test_name);
      end
      else
      begin
        compare_byte(test_name, exp_bytes.pop_front(), got_byte);
        is_second = exp_second.pop_front();
        if (is_second && got_start - last_start < MIN_SPACING)
        begin
          errors++;
          $display("** Error %s: frame spacing expected >= %0d actual %0d",
                   test_name, MIN_SPACING, got_start - last_start);
        end
      end
      last_start = got_start;
    end
    if (rst_n && read_rdy)
    begin
      if (exp_rsps.size() == 0)
      begin
        errors++;
        $display("read_rdy pulsed with no read waiting in %s", test_name);
      end
      else
        compare_rsp(test_name, exp_rsps.pop_front(), rsp);
    end
  end

  initial
  begin
    cmd_t        c;
    logic [31:0] r;
    uart_byte_t  reply;
    logic        bad_par;
    logic        bad_stop;
    rst_n   = 1'b0;
    cmd     = '0;
    cmd_vld = 1'b0;
    rx      = 1'b1;
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    test_name = "after_reset";
    compare_level({test_name, " cmd_rdy"}, 1'b1, cmd_rdy);
    compare_level({test_name, " tx"}, 1'b1, tx);
    compare_level({test_name, " read_rdy"}, 1'b0, read_rdy);

    test_name = "write";
    run_write(cmd_t'{rw: 1'b1, addr: 7'h15, data: 8'hc3});

    test_name = "read_good";
    run_read(cmd_t'{rw: 1'b0, addr: 7'h33, data: 8'h00}, 8'h96, 1'b0, 1'b0);

    test_name = "read_bad_parity";
    run_read(cmd_t'{rw: 1'b0, addr: 7'h0f, data: 8'h7e}, 8'h41, 1'b1, 1'b0);
    test_name = "read_bad_stop";
    run_read(cmd_t'{rw: 1'b0, addr: 7'h70, data: 8'h11}, 8'hd2, 1'b0, 1'b1);

    test_name = "busy_ignore";
    issue_cmd(cmd_t'{rw: 1'b1, addr: 7'h2a, data: 8'h5c});
    hold_vld_while_busy(64);
    send_frame(8'ha5, 1'b0, 1'b0);  // Dropped since no read is pending
    wait_done();

    test_name = "random";
    for (int i = 0; i < 200; i++)
    begin
      r = rand_bits(16);
      c = cmd_t'(r[15:0]);
      if (c.rw)
        run_write(c);
      else
      begin
        r        = rand_bits(8);
        reply    = r[7:0];
        bad_par  = (rand_bits(3) == 32'd0);
        bad_stop = (rand_bits(3) == 32'd0);
        run_read(c, reply, bad_par, bad_stop);
      end
    end

    repeat (2 * BIT_CYCLES) @(negedge clk);
    if (seen_bytes.size() != 0 || exp_bytes.size() != 0 || exp_rsps.size() != 0)
    begin
      errors++;
      $display("Frames or responses were left over at the end of the run");
    end
    finish_run();
  end

endmodule

// ==== hw/uart_cmd_top.sv ====
`timescale 1ns/10ps

module uart_cmd_top
  import uart_pkg::*;
  import cmd_pkg::*;
#(
  parameter int BIT_CYCLES = 434,
  parameter int GAP_BITS   = 16
) (
  input  logic      clk,
  input  logic      rst_n,
  input  cmd_t      cmd,
  input  logic      cmd_vld,
  output logic      cmd_rdy,
  input  logic      rx,
  output logic      tx,
  output logic      read_rdy,
  output read_rsp_t rsp
);

  logic       tx_start;
  uart_byte_t tx_byte;
  logic       tx_busy;
  logic       rx_done;
  rx_result_t rx_result;

  cmd_engine #(
    .GAP_BITS   (GAP_BITS),
    .BIT_CYCLES (BIT_CYCLES)
  ) engine0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd       (cmd),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .tx_start  (tx_start),
    .tx_byte   (tx_byte),
    .tx_busy   (tx_busy),
    .rx_done   (rx_done),
    .rx_result (rx_result),
    .read_rdy  (read_rdy),
    .rsp       (rsp)
  );

  uart_tx #(
    .BIT_CYCLES (BIT_CYCLES)
  ) tx0 (
    .clk   (clk),
    .rst_n (rst_n),
    .start (tx_start),
    .data  (tx_byte),
    .busy  (tx_busy),
    .tx    (tx)
  );

  uart_rx #(
    .BIT_CYCLES (BIT_CYCLES)
  ) rx0 (
    .clk    (clk),
    .rst_n  (rst_n),
    .rx     (rx),
    .done   (rx_done),
    .result (rx_result)
  );

endmodule

// ==== hw/cmd_engine.sv ====
`timescale 1ns/10ps

module cmd_engine
  import uart_pkg::*;
  import cmd_pkg::*;
#(
  parameter int GAP_BITS   = 16,
  parameter int BIT_CYCLES = 434
) (
  input  logic       clk,
  input  logic       rst_n,
  input  cmd_t       cmd,
  input  logic       cmd_vld,
  output logic       cmd_rdy,
  output logic       tx_start,
  output uart_byte_t tx_byte,
  input  logic       tx_busy,
  input  logic       rx_done,
  input  rx_result_t rx_result,
  output logic       read_rdy,
  output read_rsp_t  rsp
);

  localparam int GAP_CYCLES = GAP_BITS * BIT_CYCLES;
  localparam int GAP_W      = $clog2(GAP_CYCLES + 1);

  typedef enum logic [2:0] {
    S_IDLE,
    S_SEND_CMD,
    S_GAP,
    S_SEND_DATA,
    S_WAIT_REPLY,
    S_DONE
  } state_t;

  state_t           state;
  cmd_t             cmd_q;
  logic [GAP_W-1:0] gap_cnt;
  logic             accept;
  logic             tx_idle;

  // A new command may also be taken in the done cycle
  assign cmd_rdy  = (state == S_IDLE) || (state == S_DONE);
  assign accept   = cmd_vld && cmd_rdy;
  assign tx_idle  = !tx_start && !tx_busy;  // busy lags start by a cycle
  assign read_rdy = (state == S_DONE) && (cmd_q.rw == CMD_READ);
  assign tx_byte  = (state == S_SEND_DATA) ? cmd_q.data : cmd_byte(cmd_q);

  always_ff @(posedge clk)
  begin
    if (accept)
      cmd_q <= cmd;
  end

  always_ff @(posedge clk)
  begin
    if (state == S_WAIT_REPLY && rx_done)
    begin
      rsp.data <= rx_result.data;
      rsp.err  <= rx_result.parity_err | rx_result.stop_err;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= S_IDLE;
      tx_start <= 1'b0;
      gap_cnt  <= '0;
    end
    else
    begin
      tx_start <= 1'b0;
      case (state)
        S_IDLE, S_DONE:
        begin
          if (accept)
          begin
            state    <= S_SEND_CMD;
            tx_start <= 1'b1;
          end
          else
            state <= S_IDLE;
        end
        S_SEND_CMD:
        begin
          if (tx_idle)
          begin
            gap_cnt <= '0;
            state   <= (cmd_q.rw == CMD_WRITE) ? S_GAP : S_WAIT_REPLY;
          end
        end
        S_GAP:
        begin
          if (gap_cnt == GAP_W'(GAP_CYCLES - 1))
          begin
            state    <= S_SEND_DATA;
            tx_start <= 1'b1;
          end
          else
            gap_cnt <= gap_cnt + 1'b1;
        end
        S_SEND_DATA:
        begin
          if (tx_idle)
            state <= S_DONE;
        end
        S_WAIT_REPLY:
        begin
          if (rx_done)
            state <= S_DONE;  // No timeout here
        end
        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

// ==== hw/uart_rx.sv ====
`timescale 1ns/10ps

module uart_rx
  import uart_pkg::*;
#(
  parameter int BIT_CYCLES = 434
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       rx,
  output logic       done,
  output rx_result_t result
);

  localparam int CNT_W = $clog2(BIT_CYCLES);
  localparam int IDX_W = $clog2(FRAME_BITS);

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_BITS
  } rx_state_t;

  rx_state_t          state;
  logic               rx_s1;
  logic               rx_s2;
  logic               rx_d;
  logic [CNT_W-1:0]   baud_cnt;
  logic [IDX_W-1:0]   bit_idx;
  logic [DATA_BITS:0] shreg;  // Parity lands in the top bit
  logic               fall;
  logic               mid_start;
  logic               mid_bit;
  logic               last_bit;

  assign fall      = rx_d & ~rx_s2;
  assign mid_start = (baud_cnt == CNT_W'(BIT_CYCLES / 2 - 1));
  assign mid_bit   = (baud_cnt == CNT_W'(BIT_CYCLES - 1));
  assign last_bit  = (bit_idx == IDX_W'(FRAME_BITS - 1));

  // Line comes in asynchronously
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_s1 <= LINE_IDLE;
      rx_s2 <= LINE_IDLE;
      rx_d  <= LINE_IDLE;
    end
    else
    begin
      rx_s1 <= rx;
      rx_s2 <= rx_s1;
      rx_d  <= rx_s2;
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == RX_BITS && mid_bit && !last_bit)
      shreg <= {rx_s2, shreg[DATA_BITS:1]};
  end

  // Sampled at the middle of the stop bit
  always_ff @(posedge clk)
  begin
    if (state == RX_BITS && mid_bit && last_bit)
    begin
      result.data       <= shreg[DATA_BITS-1:0];
      result.parity_err <= ^shreg;
      result.stop_err   <= ~rx_s2;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= RX_IDLE;
      baud_cnt <= '0;
      bit_idx  <= '0;
      done     <= 1'b0;
    end
    else
    begin
      done <= 1'b0;
      case (state)
        RX_IDLE:
        begin
          baud_cnt <= '0;
          if (fall)
            state <= RX_START;
        end
        RX_START:
        begin
          if (mid_start)
          begin
            baud_cnt <= '0;
            bit_idx  <= IDX_W'(1);
            state    <= (rx_s2 == START_BIT) ? RX_BITS : RX_IDLE;  // Glitch check
          end
          else
            baud_cnt <= baud_cnt + 1'b1;
        end
        RX_BITS:
        begin
          if (mid_bit)
          begin
            baud_cnt <= '0;
            if (last_bit)
            begin
              done  <= 1'b1;
              state <= RX_IDLE;
            end
            else
              bit_idx <= bit_idx + 1'b1;
          end
          else
            baud_cnt <= baud_cnt + 1'b1;
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

endmodule

// ==== hw/uart_tx.sv ====
`timescale 1ns/10ps

module uart_tx
  import uart_pkg::*;
#(
  parameter int BIT_CYCLES = 434
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       start,
  input  uart_byte_t data,
  output logic       busy,
  output logic       tx
);

  localparam int CNT_W = $clog2(BIT_CYCLES);
  localparam int IDX_W = $clog2(FRAME_BITS);

  logic [CNT_W-1:0]     baud_cnt;
  logic [IDX_W-1:0]     bit_idx;
  logic [DATA_BITS+1:0] shreg;  // Bits still to go with stop on top
  logic                 bit_end;

  assign bit_end = (baud_cnt == CNT_W'(BIT_CYCLES - 1));

  // Byte and parity are taken at start and then shifted out LSB first
  always_ff @(posedge clk)
  begin
    if (start && !busy)
      shreg <= {LINE_IDLE, even_parity(data), data};
    else if (busy && bit_end)
      shreg <= {LINE_IDLE, shreg[DATA_BITS+1:1]};
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy     <= 1'b0;
      tx       <= LINE_IDLE;
      baud_cnt <= '0;
      bit_idx  <= '0;
    end
    else if (!busy)
    begin
      if (start)
      begin
        busy     <= 1'b1;
        tx       <= START_BIT;
        baud_cnt <= '0;
        bit_idx  <= '0;
      end
    end
    else if (bit_end)
    begin
      baud_cnt <= '0;
      if (bit_idx == IDX_W'(FRAME_BITS - 1))
        busy <= 1'b0;  // Stop bit done and line already high
      else
      begin
        bit_idx <= bit_idx + 1'b1;
        tx      <= shreg[0];
      end
    end
    else
    begin
      baud_cnt <= baud_cnt + 1'b1;
    end
  end

endmodule

// ==== hw/cmd_pkg.sv ====
package cmd_pkg;

  import uart_pkg::*;

  localparam logic CMD_WRITE = 1'b1;
  localparam logic CMD_READ  = 1'b0;

  localparam int ADDR_BITS = 7;

  // Host command whose upper byte goes out first
  typedef struct packed {
    logic                 rw;    // 1 means write
    logic [ADDR_BITS-1:0] addr;
    uart_byte_t           data;
  } cmd_t;

  typedef struct packed {
    uart_byte_t data;
    logic       err;
  } read_rsp_t;

  // Command byte as it appears in the first frame
  function automatic uart_byte_t cmd_byte(input cmd_t c);
    cmd_byte = {c.rw, c.addr};
  endfunction

endpackage

// ==== hw/uart_pkg.sv ====
package uart_pkg;

  // Frame layout on the line
  localparam int DATA_BITS  = 8;
  localparam int FRAME_BITS = 11;  // Start, eight data, parity, stop

  localparam logic LINE_IDLE  = 1'b1;
  localparam logic START_BIT  = 1'b0;

  typedef logic [DATA_BITS-1:0] uart_byte_t;

  // What the receiver hands over at the end of a frame
  typedef struct packed {
    uart_byte_t data;
    logic       parity_err;  // Even parity did not hold
    logic       stop_err;    // Stop bit sampled low
  } rx_result_t;

  // Even parity bit for a data byte
  function automatic logic even_parity(input uart_byte_t b);
    even_parity = ^b;
  endfunction

endpackage
